// File: Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := csr_unit_tb
RTL_TOP    := csr_unit_top
FLIST      := flist.f
OBJ_DIR    := obj_dir
PASS_MSG   := TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: design/csr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module csr_decoder (
    input  logic                clock,
    input  logic                rst,
    input  logic                inst_valid,
    input  csr_pkg::inst_in_t   inst,
    output logic                req_valid,
    output csr_pkg::csr_req_t   req
);

    logic [6:0]        opcode;
    logic [4:0]        rd_idx;
    logic [2:0]        funct3;
    logic [4:0]        rs1_idx;
    logic [11:0]       funct12;
    logic [31:0]       zimm;
    logic              dec_hit;
    csr_pkg::csr_req_t dec_req;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field extraction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign opcode  = inst.inst[6:0];
    assign rd_idx  = inst.inst[11:7];
    assign funct3  = inst.inst[14:12];
    assign rs1_idx = inst.inst[19:15];
    assign funct12 = inst.inst[31:20];
    assign zimm    = {27'd0, rs1_idx};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        dec_hit         = 1'b0;
        dec_req.op      = rv_isa_pkg::OP_RW;
        dec_req.addr    = funct12;
        dec_req.operand = inst.rs1_data;
        dec_req.write   = 1'b1;
        dec_req.rd      = rd_idx;
        dec_req.pc      = inst.pc;

        if (opcode == rv_isa_pkg::opcode_system) begin
            case (funct3)
                rv_isa_pkg::F3_PRIV: begin
                    // no CSR access and no write-back
                    dec_req.write   = 1'b0;
                    dec_req.rd      = 5'd0;
                    dec_req.operand = '0;
                    if (funct12 == rv_isa_pkg::funct12_ecall) begin
                        dec_hit    = 1'b1;
                        dec_req.op = rv_isa_pkg::OP_ECALL;
                    end else if (funct12 == rv_isa_pkg::funct12_mret) begin
                        dec_hit    = 1'b1;
                        dec_req.op = rv_isa_pkg::OP_MRET;
                    end
                end
                rv_isa_pkg::F3_CSRRW: begin
                    dec_hit    = 1'b1;
                    dec_req.op = rv_isa_pkg::OP_RW;
                end
                rv_isa_pkg::F3_CSRRS: begin
                    dec_hit       = 1'b1;
                    dec_req.op    = rv_isa_pkg::OP_RS;
                    dec_req.write = (rs1_idx != 5'd0);
                end
                rv_isa_pkg::F3_CSRRC: begin
                    dec_hit       = 1'b1;
                    dec_req.op    = rv_isa_pkg::OP_RC;
                    dec_req.write = (rs1_idx != 5'd0);
                end
                rv_isa_pkg::F3_CSRRWI: begin
                    dec_hit         = 1'b1;
                    dec_req.op      = rv_isa_pkg::OP_RW;
                    dec_req.operand = zimm;
                end
                rv_isa_pkg::F3_CSRRSI: begin
                    dec_hit         = 1'b1;
                    dec_req.op      = rv_isa_pkg::OP_RS;
                    dec_req.operand = zimm;
                    dec_req.write   = (rs1_idx != 5'd0);
                end
                rv_isa_pkg::F3_CSRRCI: begin
                    dec_hit         = 1'b1;
                    dec_req.op      = rv_isa_pkg::OP_RC;
                    dec_req.operand = zimm;
                    dec_req.write   = (rs1_idx != 5'd0);
                end
                default: begin
                    // funct3 = 100 is reserved, dropped
                    dec_hit = 1'b0;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= inst_valid && dec_hit;
        end
    end

    always_ff @(posedge clock) begin
        if (inst_valid && dec_hit) begin
            req <= dec_req;
        end
    end

    // a request only ever follows a retiring instruction by one cycle
    a_req_follows_inst: assert property (
        @(posedge clock) disable iff (rst)
        req_valid |-> $past(inst_valid)
    ) else $error("csr_decoder: req_valid without inst_valid one cycle earlier");

endmodule

`default_nettype wire

// File: design/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
    parameter logic [31:0] MTVEC_RESET = 32'h8000_0100
) (
    input  logic                clock,
    input  logic                rst,
    input  logic                req_valid,
    input  csr_pkg::csr_req_t   req,
    output logic                rsp_valid,
    output csr_pkg::csr_rsp_t   rsp
);

    logic [31:0]       mstatus;
    logic [31:0]       mtvec;
    logic [31:0]       mepc;
    logic [31:0]       mcause;

    logic [31:0]       csr_rdata;
    logic [31:0]       csr_wdata;
    logic              addr_known;
    logic              is_access;
    logic              csr_wen;
    logic              do_ecall;
    logic              do_mret;
    csr_pkg::csr_rsp_t rsp_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read and modify
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        addr_known = 1'b1;
        case (req.addr)
            rv_isa_pkg::CSR_MSTATUS: csr_rdata = mstatus;
            rv_isa_pkg::CSR_MTVEC:   csr_rdata = mtvec;
            rv_isa_pkg::CSR_MEPC:    csr_rdata = mepc;
            rv_isa_pkg::CSR_MCAUSE:  csr_rdata = mcause;
            default: begin
                // unimplemented address reads as zero
                csr_rdata  = '0;
                addr_known = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (req.op)
            rv_isa_pkg::OP_RS: csr_wdata = csr_rdata | req.operand;
            rv_isa_pkg::OP_RC: csr_wdata = csr_rdata & ~req.operand;
            default:           csr_wdata = req.operand;
        endcase
    end

    assign is_access = req.op inside {rv_isa_pkg::OP_RW, rv_isa_pkg::OP_RS, rv_isa_pkg::OP_RC};
    assign csr_wen   = req_valid && is_access && req.write && addr_known;
    assign do_ecall  = req_valid && (req.op == rv_isa_pkg::OP_ECALL);
    assign do_mret   = req_valid && (req.op == rv_isa_pkg::OP_MRET);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mstatus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (rst) begin
            mstatus <= rv_isa_pkg::mstatus_reset;
        end else if (do_ecall) begin
            // trap entry stacks the interrupt enable
            mstatus[rv_isa_pkg::mstatus_mpie_bit] <= mstatus[rv_isa_pkg::mstatus_mie_bit];
            mstatus[rv_isa_pkg::mstatus_mie_bit]  <= 1'b0;
        end else if (do_mret) begin
            mstatus[rv_isa_pkg::mstatus_mie_bit]  <= mstatus[rv_isa_pkg::mstatus_mpie_bit];
            mstatus[rv_isa_pkg::mstatus_mpie_bit] <= 1'b1;
        end else if (csr_wen && req.addr == rv_isa_pkg::CSR_MSTATUS) begin
            mstatus <= csr_wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mtvec
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (rst) begin
            mtvec <= MTVEC_RESET;
        end else if (csr_wen && req.addr == rv_isa_pkg::CSR_MTVEC) begin
            mtvec <= csr_wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mepc
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (rst) begin
            mepc <= '0;
        end else if (do_ecall) begin
            // pc of the ECALL itself, handler steps past it
            mepc <= req.pc;
        end else if (csr_wen && req.addr == rv_isa_pkg::CSR_MEPC) begin
            mepc <= csr_wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mcause
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (rst) begin
            mcause <= '0;
        end else if (do_ecall) begin
            mcause <= rv_isa_pkg::cause_ecall_m;
        end else if (csr_wen && req.addr == rv_isa_pkg::CSR_MCAUSE) begin
            mcause <= csr_wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        rsp_d.rd_wen   = req_valid && is_access && (req.rd != 5'd0);
        rsp_d.rd       = req.rd;
        rsp_d.rd_data  = csr_rdata;
        rsp_d.redirect = do_ecall || do_mret;
        // vectored mode is not supported, mode bits are ignored
        rsp_d.target   = do_ecall ? {mtvec[31:2], 2'b00} : mepc;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge clock) begin
        rsp <= rsp_d;
    end

    a_redirect_source: assert property (
        @(posedge clock) disable iff (rst)
        (rsp_valid && rsp.redirect) |->
            $past(req_valid && (req.op inside {rv_isa_pkg::OP_ECALL, rv_isa_pkg::OP_MRET}))
    ) else $error("csr_file: redirect without an ECALL or MRET request");

    a_wen_redirect_excl: assert property (
        @(posedge clock) disable iff (rst)
        rsp_valid |-> !(rsp.rd_wen && rsp.redirect)
    ) else $error("csr_file: rd_wen and redirect both set");

endmodule

`default_nettype wire

// File: design/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // retiring instruction as seen at the end of execute
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] rs1_data;
    } inst_in_t;

    // decoded CSR request
    typedef struct packed {
        rv_isa_pkg::csr_op_e op;
        logic [11:0]         addr;
        // rs1_data, or zimm zero-extended
        logic [31:0]         operand;
        // low for set/clear forms with rs1 or zimm of zero
        logic                write;
        logic [4:0]          rd;
        logic [31:0]         pc;
    } csr_req_t;

    // write-back and pc redirect
    typedef struct packed {
        logic        rd_wen;
        logic [4:0]  rd;
        logic [31:0] rd_data;
        logic        redirect;
        logic [31:0] target;
    } csr_rsp_t;

endpackage

`default_nettype wire

// File: design/csr_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top #(
    parameter logic [31:0] MTVEC_RESET = 32'h8000_0100
) (
    input  logic                clock,
    input  logic                rst,
    input  logic                inst_valid,
    input  csr_pkg::inst_in_t   inst,
    output logic                rsp_valid,
    output csr_pkg::csr_rsp_t   rsp
);

    logic              req_valid;
    csr_pkg::csr_req_t req;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode stage, one cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    csr_decoder u_decoder (
        .clock      (clock),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .req_valid  (req_valid),
        .req        (req)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CSR access and trap, one cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_csr_file (
        .clock      (clock),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule

`default_nettype wire

// File: design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // major opcode shared by CSR access, ECALL and MRET
    localparam logic [6:0] opcode_system = 7'b1110011;

    // funct3 field of a SYSTEM instruction, 3'b100 is left unused
    typedef enum logic [2:0] {
        F3_PRIV   = 3'b000,
        F3_CSRRW  = 3'b001,
        F3_CSRRS  = 3'b010,
        F3_CSRRC  = 3'b011,
        F3_CSRRWI = 3'b101,
        F3_CSRRSI = 3'b110,
        F3_CSRRCI = 3'b111
    } funct3_e;

    // machine CSRs implemented by the CSR file
    typedef enum logic [11:0] {
        CSR_MSTATUS = 12'h300,
        CSR_MTVEC   = 12'h305,
        CSR_MEPC    = 12'h341,
        CSR_MCAUSE  = 12'h342
    } csr_addr_e;

    // operation carried from the decoder to the CSR file
    typedef enum logic [2:0] {
        OP_RW    = 3'd0,
        OP_RS    = 3'd1,
        OP_RC    = 3'd2,
        OP_ECALL = 3'd3,
        OP_MRET  = 3'd4
    } csr_op_e;

    // funct12 tells the PRIV instructions apart
    localparam logic [11:0] funct12_ecall = 12'h000;
    localparam logic [11:0] funct12_mret  = 12'h302;

    // mstatus fields
    localparam int unsigned mstatus_mie_bit  = 3;
    localparam int unsigned mstatus_mpie_bit = 7;

    // MPP = M, interrupts disabled
    localparam logic [31:0] mstatus_reset = 32'h0000_1800;

    localparam logic [31:0] cause_ecall_m = 32'd11;

endpackage

`default_nettype wire

// File: flist.f
design/rv_isa_pkg.sv
design/csr_pkg.sv
design/csr_decoder.sv
design/csr_file.sv
design/csr_unit_top.sv
verification/csr_unit_tb.sv

// File: verification/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

    localparam logic [31:0] mtvec_reset = 32'h8000_0181;
    localparam int n_access = 60;
    localparam int n_trap = 8;
    localparam int n_dense = 250;
    // every issued instruction takes one 20 ns cycle
    localparam int issued_total = 4 + 2 * n_access + 10 * n_trap + 12 + n_dense;
    localparam int timeout_ns = (issued_total + 60) * 20;

    typedef struct packed {
        logic              valid;
        logic              access;
        csr_pkg::csr_rsp_t rsp;
    } exp_t;

    logic              clock = 1'b0;
    logic              rst;
    logic              inst_valid;
    csr_pkg::inst_in_t inst;
    logic              rsp_valid;
    csr_pkg::csr_rsp_t rsp;

    // shadow CSRs
    logic [31:0] m_mstatus;
    logic [31:0] m_mtvec;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;

    exp_t        exp_cur;
    exp_t        exp_line [2];
    logic [31:0] pc;
    integer      seed;
    int          responses_seen = 0;
    int          responses_expected = 0;

    csr_unit_top #(
        .MTVEC_RESET (mtvec_reset)
    ) DUT (
        .clock      (clock),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    always #10 clock = ~clock;

    // expected responses in flight, two cycles deep
    always @(posedge clock) begin
        if (rst) begin
            exp_line[0] <= '0;
            exp_line[1] <= '0;
        end else begin
            exp_line[0] <= exp_cur;
            exp_line[1] <= exp_line[0];
            if (rsp_valid) begin
                responses_seen <= responses_seen + 1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH at %0t ns: %s expected 0x%08h, got 0x%08h",
                 $time, name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "response check failed");
    endtask

    a_rsp_valid: assert property (
        @(posedge clock) disable iff (rst)
        rsp_valid == exp_line[1].valid
    ) else report_mismatch("rsp_valid", $sampled(exp_line[1].valid), $sampled(rsp_valid));

    a_rd_wen: assert property (
        @(posedge clock) disable iff (rst)
        exp_line[1].valid |-> rsp.rd_wen == exp_line[1].rsp.rd_wen
    ) else report_mismatch("rsp.rd_wen", $sampled(exp_line[1].rsp.rd_wen),
                           $sampled(rsp.rd_wen));

    a_rd: assert property (
        @(posedge clock) disable iff (rst)
        (exp_line[1].valid && exp_line[1].access) |-> rsp.rd == exp_line[1].rsp.rd
    ) else report_mismatch("rsp.rd", $sampled(exp_line[1].rsp.rd), $sampled(rsp.rd));

    a_rd_data: assert property (
        @(posedge clock) disable iff (rst)
        (exp_line[1].valid && exp_line[1].access) |-> rsp.rd_data == exp_line[1].rsp.rd_data
    ) else report_mismatch("rsp.rd_data", $sampled(exp_line[1].rsp.rd_data),
                           $sampled(rsp.rd_data));

    a_redirect: assert property (
        @(posedge clock) disable iff (rst)
        exp_line[1].valid |-> rsp.redirect == exp_line[1].rsp.redirect
    ) else report_mismatch("rsp.redirect", $sampled(exp_line[1].rsp.redirect),
                           $sampled(rsp.redirect));

    a_target: assert property (
        @(posedge clock) disable iff (rst)
        (exp_line[1].valid && exp_line[1].rsp.redirect) |-> rsp.target == exp_line[1].rsp.target
    ) else report_mismatch("rsp.target", $sampled(exp_line[1].rsp.target),
                           $sampled(rsp.target));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shadow model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic predict(input csr_pkg::inst_in_t in, output exp_t e);
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [11:0] addr;
        logic [31:0] old_val;
        logic [31:0] operand;
        logic [31:0] new_val;
        logic        known;
        f3 = in.inst[14:12];
        rs1 = in.inst[19:15];
        addr = in.inst[31:20];
        e = '0;
        if (in.inst[6:0] != rv_isa_pkg::opcode_system || f3 == 3'b100) begin
            return;
        end
        if (f3 == rv_isa_pkg::F3_PRIV) begin
            if (addr == rv_isa_pkg::funct12_ecall) begin
                e.valid = 1'b1;
                e.rsp.redirect = 1'b1;
                e.rsp.target = {m_mtvec[31:2], 2'b00};
                m_mepc = in.pc;
                m_mcause = rv_isa_pkg::cause_ecall_m;
                m_mstatus[rv_isa_pkg::mstatus_mpie_bit] = m_mstatus[rv_isa_pkg::mstatus_mie_bit];
                m_mstatus[rv_isa_pkg::mstatus_mie_bit] = 1'b0;
            end else if (addr == rv_isa_pkg::funct12_mret) begin
                e.valid = 1'b1;
                e.rsp.redirect = 1'b1;
                e.rsp.target = m_mepc;
                m_mstatus[rv_isa_pkg::mstatus_mie_bit] = m_mstatus[rv_isa_pkg::mstatus_mpie_bit];
                m_mstatus[rv_isa_pkg::mstatus_mpie_bit] = 1'b1;
            end
            return;
        end
        known = 1'b1;
        case (addr)
            rv_isa_pkg::CSR_MSTATUS: old_val = m_mstatus;
            rv_isa_pkg::CSR_MTVEC:   old_val = m_mtvec;
            rv_isa_pkg::CSR_MEPC:    old_val = m_mepc;
            rv_isa_pkg::CSR_MCAUSE:  old_val = m_mcause;
            default: begin
                old_val = '0;
                known = 1'b0;
            end
        endcase
        // funct3[2] picks the immediate form, funct3[1:0] the access kind
        operand = f3[2] ? {27'd0, rs1} : in.rs1_data;
        case (f3[1:0])
            2'b01:   new_val = operand;
            2'b10:   new_val = old_val | operand;
            default: new_val = old_val & ~operand;
        endcase
        e.valid = 1'b1;
        e.access = 1'b1;
        e.rsp.rd = in.inst[11:7];
        e.rsp.rd_wen = (in.inst[11:7] != 5'd0);
        e.rsp.rd_data = old_val;
        if (known && (f3[1:0] == 2'b01 || rs1 != 5'd0)) begin
            case (addr)
                rv_isa_pkg::CSR_MSTATUS: m_mstatus = new_val;
                rv_isa_pkg::CSR_MTVEC:   m_mtvec = new_val;
                rv_isa_pkg::CSR_MEPC:    m_mepc = new_val;
                default:                 m_mcause = new_val;
            endcase
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] enc_csr(input logic [2:0] f3, input logic [11:0] addr,
                                            input logic [4:0] rs1, input logic [4:0] rd);
        return {addr, rs1, f3, rd, rv_isa_pkg::opcode_system};
    endfunction

    function automatic logic [31:0] enc_priv(input logic [11:0] f12);
        return {f12, 5'd0, rv_isa_pkg::F3_PRIV, 5'd0, rv_isa_pkg::opcode_system};
    endfunction

    function automatic logic [11:0] pick_addr(input logic [2:0] sel);
        case (sel)
            3'd0, 3'd1: return rv_isa_pkg::CSR_MSTATUS;
            3'd2:       return rv_isa_pkg::CSR_MTVEC;
            3'd3, 3'd4: return rv_isa_pkg::CSR_MEPC;
            3'd5, 3'd6: return rv_isa_pkg::CSR_MCAUSE;
            default:    return 12'h340;
        endcase
    endfunction

    function automatic logic [2:0] pick_f3(input logic [2:0] sel);
        case (sel)
            3'd0:       return rv_isa_pkg::F3_CSRRW;
            3'd1, 3'd6: return rv_isa_pkg::F3_CSRRS;
            3'd2, 3'd7: return rv_isa_pkg::F3_CSRRC;
            3'd3:       return rv_isa_pkg::F3_CSRRWI;
            3'd4:       return rv_isa_pkg::F3_CSRRSI;
            default:    return rv_isa_pkg::F3_CSRRCI;
        endcase
    endfunction

    task automatic issue(input logic [31:0] word, input logic [31:0] rs1_data);
        csr_pkg::inst_in_t in;
        exp_t              e;
        in.pc = pc;
        in.inst = word;
        in.rs1_data = rs1_data;
        @(posedge clock);
        #1;
        predict(in, e);
        inst = in;
        inst_valid = 1'b1;
        exp_cur = e;
        if (e.valid) begin
            responses_expected = responses_expected + 1;
        end
        pc = pc + 32'd4;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            #1;
            inst_valid = 1'b0;
            exp_cur = '0;
        end
    endtask

    task automatic read_csr(input logic [11:0] addr);
        issue(enc_csr(rv_isa_pkg::F3_CSRRS, addr, 5'd0, 5'd10), $random(seed));
    endtask

    task automatic issue_random_access(output logic [11:0] addr);
        logic [31:0] r;
        logic [4:0]  rs1;
        r = $random(seed);
        addr = pick_addr(r[5:3]);
        // rs1 of x0 about a quarter of the time
        rs1 = (r[9:8] == 2'b00) ? 5'd0 : r[14:10];
        issue(enc_csr(pick_f3(r[2:0]), addr, rs1, r[19:15]), $random(seed));
    endtask

    task automatic issue_random_any();
        logic [31:0] r;
        logic [11:0] addr;
        r = $random(seed);
        case (r[3:0])
            4'd0: issue(enc_priv(rv_isa_pkg::funct12_ecall), 32'd0);
            4'd1: issue(enc_priv(rv_isa_pkg::funct12_mret), 32'd0);
            4'd2: issue({r[31:7], 7'b0010011}, $random(seed));
            4'd3: issue(enc_priv(12'h105), 32'd0);
            4'd4: issue({r[31:15], 3'b100, r[11:7], rv_isa_pkg::opcode_system}, 32'd0);
            default: issue_random_access(addr);
        endcase
    endtask

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns, the stimulus did not finish", timeout_ns);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [11:0] addr;
        seed = 32'ha449_8110;
        rst = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        exp_cur = '0;
        pc = 32'h0000_1000;
        m_mstatus = rv_isa_pkg::mstatus_reset;
        m_mtvec = mtvec_reset;
        m_mepc = '0;
        m_mcause = '0;
        repeat (3) @(posedge clock);
        #1;
        rst = 1'b0;

        read_csr(rv_isa_pkg::CSR_MSTATUS);
        read_csr(rv_isa_pkg::CSR_MTVEC);
        read_csr(rv_isa_pkg::CSR_MEPC);
        read_csr(rv_isa_pkg::CSR_MCAUSE);
        idle(2);

        // each access is read back on the very next cycle
        repeat (n_access) begin
            issue_random_access(addr);
            read_csr(addr);
        end
        idle(2);

        for (int i = 0; i < n_trap; i++) begin
            issue(enc_csr(rv_isa_pkg::F3_CSRRW, rv_isa_pkg::CSR_MTVEC, 5'd1, 5'd0), $random(seed));
            if (i % 2 == 0) begin
                issue(enc_csr(rv_isa_pkg::F3_CSRRSI, rv_isa_pkg::CSR_MSTATUS, 5'd8, 5'd0), 32'd0);
            end else begin
                issue(enc_csr(rv_isa_pkg::F3_CSRRCI, rv_isa_pkg::CSR_MSTATUS, 5'd8, 5'd0), 32'd0);
            end
            issue(enc_priv(rv_isa_pkg::funct12_ecall), 32'd0);
            read_csr(rv_isa_pkg::CSR_MEPC);
            read_csr(rv_isa_pkg::CSR_MCAUSE);
            read_csr(rv_isa_pkg::CSR_MSTATUS);
            issue(enc_csr(rv_isa_pkg::F3_CSRRW, rv_isa_pkg::CSR_MEPC, 5'd2, 5'd3), $random(seed));
            // toggle MPIE before the return
            if (i % 3 == 0) begin
                issue(enc_csr(rv_isa_pkg::F3_CSRRC, rv_isa_pkg::CSR_MSTATUS, 5'd4, 5'd0), 32'h80);
            end else begin
                issue(enc_csr(rv_isa_pkg::F3_CSRRS, rv_isa_pkg::CSR_MSTATUS, 5'd4, 5'd0), 32'h80);
            end
            issue(enc_priv(rv_isa_pkg::funct12_mret), 32'd0);
            read_csr(rv_isa_pkg::CSR_MSTATUS);
        end
        idle(2);

        // addi, ebreak, wfi, sret and reserved funct3 are all dropped
        issue(32'h0051_0093, 32'd7);
        issue(enc_priv(12'h001), 32'd0);
        issue(enc_priv(12'h105), 32'd0);
        issue(enc_priv(12'h102), 32'd0);
        issue({12'h300, 5'd1, 3'b100, 5'd2, rv_isa_pkg::opcode_system}, $random(seed));
        issue(enc_csr(rv_isa_pkg::F3_CSRRW, rv_isa_pkg::CSR_MCAUSE, 5'd5, 5'd0), 32'h1234_5678);
        issue(enc_csr(rv_isa_pkg::F3_CSRRW, 12'h7c0, 5'd6, 5'd7), 32'hdead_beef);
        read_csr(12'h7c0);
        read_csr(rv_isa_pkg::CSR_MSTATUS);
        read_csr(rv_isa_pkg::CSR_MTVEC);
        read_csr(rv_isa_pkg::CSR_MEPC);
        read_csr(rv_isa_pkg::CSR_MCAUSE);
        idle(2);

        repeat (n_dense) begin
            issue_random_any();
        end
        idle(4);

        if (responses_seen == responses_expected) begin
            $display("TEST OK");
            $finish;
        end else begin
            report_mismatch("response count", responses_expected, responses_seen);
        end
    end

endmodule

`default_nettype wire
